//--- include/port_stats_macros.svh
// Build constants for the port statistics block
// Port counts stay at or below 32 so one register holds a bit per port
`ifndef PORT_STATS_MACROS_SVH
`define PORT_STATS_MACROS_SVH

// Port counts
`define ING_PORTS       4
`define EGR_PORTS       2

// Counter widths, egress kept narrow
`define ING_CNT_WIDTH   32
`define EGR_CNT_WIDTH   24
`define PKT_LEN_WIDTH   16

// Register file geometry, word addressed
`define REG_ADDR_WIDTH  6
`define REG_DATA_WIDTH  32

`define MODULE_ID       16'h5053
`define VERSION_MAJOR   8'd1
`define VERSION_MINOR   8'd0

`endif

//--- design/port_stats_pkg.sv
// Statistics structs and register map of the port statistics block
// The map must fit in REG_ADDR_WIDTH bits for the configured port counts
`include "port_stats_macros.svh"

package port_stats_pkg;

    localparam int CNTRS_PER_PORT = 4; // Packets, bytes, errors, drops

    //////////////////////////////
    // Per-port statistics, drop in the top bits
    typedef struct packed {
        logic [`ING_CNT_WIDTH-1:0] drop;
        logic [`ING_CNT_WIDTH-1:0] err;
        logic [`ING_CNT_WIDTH-1:0] bytes;
        logic [`ING_CNT_WIDTH-1:0] pkts;
    } ing_port_stats_t;

    typedef struct packed {
        logic [`EGR_CNT_WIDTH-1:0] drop;
        logic [`EGR_CNT_WIDTH-1:0] err;
        logic [`EGR_CNT_WIDTH-1:0] bytes;
        logic [`EGR_CNT_WIDTH-1:0] pkts;
    } egr_port_stats_t;

    //////////////////////////////
    // Word addresses
    typedef enum logic [`REG_ADDR_WIDTH-1:0] {
        VERSION_ID         = 0,  // Major, minor, module id
        NUM_REGS           = 1,
        ING_ENABLE_CON     = 2,
        EGR_ENABLE_CON     = 3,
        ING_CONNECTED_STAT = 4,
        EGR_CONNECTED_STAT = 5,
        ING_SAMPLE_CON     = 6,
        EGR_SAMPLE_CON     = 7,
        ING_COUNTERS_START = 8,
        EGR_COUNTERS_START = `REG_ADDR_WIDTH'(8 + `ING_PORTS * CNTRS_PER_PORT),
        TOTAL_REGS = `REG_ADDR_WIDTH'(8 + (`ING_PORTS + `EGR_PORTS) * CNTRS_PER_PORT)
    } reg_addr_e;

endpackage

//--- design/port_traffic_counters.sv
// Wrapping per-port traffic counters; a clear keeps the event of its own cycle
// pkt_len is only looked at in cycles where pkt_done is high
`timescale 1ns/10ps
`include "port_stats_macros.svh"
`default_nettype none

module port_traffic_counters #(
    parameter int NUM_PORTS = `ING_PORTS,
    parameter int CNT_WIDTH = `ING_CNT_WIDTH
) (
    input  var logic                                     core_clk_ifc,
    input  var logic                                     peripheral_sresetn_core,

    input  var logic [NUM_PORTS-1:0]                     pkt_done,
    input  var logic [NUM_PORTS-1:0][`PKT_LEN_WIDTH-1:0] pkt_len,
    input  var logic [NUM_PORTS-1:0]                     pkt_err,
    input  var logic [NUM_PORTS-1:0]                     buf_full_drop,
    input  var logic [NUM_PORTS-1:0]                     cnts_clear,

    output var logic [NUM_PORTS-1:0]
                     [port_stats_pkg::CNTRS_PER_PORT*CNT_WIDTH-1:0] live_stats
);

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        logic [CNT_WIDTH-1:0] pkt_cnt;
        logic [CNT_WIDTH-1:0] byte_cnt;
        logic [CNT_WIDTH-1:0] err_cnt;
        logic [CNT_WIDTH-1:0] drop_cnt;
        logic [CNT_WIDTH-1:0] byte_inc;

        assign byte_inc = pkt_done[p] ? CNT_WIDTH'(pkt_len[p]) : '0;

        // Clear restarts from this cycle's increment, nothing dropped
        always_ff @(posedge core_clk_ifc) begin
            if (!peripheral_sresetn_core) begin
                pkt_cnt  <= '0;
                byte_cnt <= '0;
                err_cnt  <= '0;
                drop_cnt <= '0;
            end else begin
                pkt_cnt  <= (cnts_clear[p] ? '0 : pkt_cnt)  + CNT_WIDTH'(pkt_done[p]);
                byte_cnt <= (cnts_clear[p] ? '0 : byte_cnt) + byte_inc;
                err_cnt  <= (cnts_clear[p] ? '0 : err_cnt)  + CNT_WIDTH'(pkt_err[p]);
                drop_cnt <= (cnts_clear[p] ? '0 : drop_cnt) + CNT_WIDTH'(buf_full_drop[p]);
            end
        end

        // Same field order as the stats structs
        assign live_stats[p] = {drop_cnt, err_cnt, byte_cnt, pkt_cnt};

        // Upstream MAC must present a length with every completed packet
        a_pkt_len_known: assert property (@(posedge core_clk_ifc)
            disable iff (!peripheral_sresetn_core)
            pkt_done[p] |-> !$isunknown(pkt_len[p]));
    end

endmodule

`default_nettype wire

//--- design/port_stats_snapshot.sv
// Latches live statistics on a rising sample bit and clears the counters
// A sample bit must drop back low before the port can be sampled again
`timescale 1ns/10ps
`default_nettype none

module port_stats_snapshot #(
    parameter type stats_t   = logic [127:0],
    parameter int  NUM_PORTS = 1
) (
    input  var logic                   core_clk_ifc,
    input  var logic                   peripheral_sresetn_core,

    input  var logic   [NUM_PORTS-1:0] sample_req,
    input  var stats_t [NUM_PORTS-1:0] live_stats,

    output var stats_t [NUM_PORTS-1:0] held_stats,
    output var logic   [NUM_PORTS-1:0] cnts_clear
);

    logic [NUM_PORTS-1:0] sample_req_d;
    logic [NUM_PORTS-1:0] sample_rise;

    assign sample_rise = sample_req & ~sample_req_d;

    //////////////////////////////
    // Edge detect and clear pulse
    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            sample_req_d <= '0;
            cnts_clear   <= '0;
        end else begin
            sample_req_d <= sample_req;
            cnts_clear   <= sample_rise; // Counters restart one cycle after the latch
        end
    end

    // Snapshot registers
    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            held_stats <= '0;
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (sample_rise[p]) begin
                    held_stats[p] <= live_stats[p];
                end
            end
        end
    end

    // A pulse that lasts two cycles would throw away an extra cycle of traffic
    a_clear_single_cycle: assert property (@(posedge core_clk_ifc)
        disable iff (!peripheral_sresetn_core)
        (cnts_clear != '0) |=> ((cnts_clear & $past(cnts_clear)) == '0));

endmodule

`default_nettype wire

//--- design/port_stats_regs.sv
// Word-addressed register file with single-cycle read and write strobes
// Reads answer one cycle later; writes to read-only or undefined words are dropped
`timescale 1ns/10ps
`include "port_stats_macros.svh"
`default_nettype none

module port_stats_regs (
    input  var logic                          core_clk_ifc,
    input  var logic                          peripheral_sresetn_core,

    input  var logic                          wr_en,
    input  var logic                          rd_en,
    input  var logic [`REG_ADDR_WIDTH-1:0]    addr,
    input  var logic [`REG_DATA_WIDTH-1:0]    wr_data,
    output var logic [`REG_DATA_WIDTH-1:0]    rd_data,
    output var logic                          rd_valid,
    output var logic                          rd_error,

    input  var logic [`ING_PORTS-1:0]         ing_connected,
    input  var logic [`EGR_PORTS-1:0]         egr_connected,
    input  var port_stats_pkg::ing_port_stats_t [`ING_PORTS-1:0] ing_held,
    input  var port_stats_pkg::egr_port_stats_t [`EGR_PORTS-1:0] egr_held,

    output var logic [`ING_PORTS-1:0]         ing_port_enable,
    output var logic [`EGR_PORTS-1:0]         egr_port_enable,
    output var logic [`ING_PORTS-1:0]         ing_sample_req,
    output var logic [`EGR_PORTS-1:0]         egr_sample_req
);

    import port_stats_pkg::*;

    logic [`ING_PORTS-1:0]      ing_enable_con;
    logic [`EGR_PORTS-1:0]      egr_enable_con;
    logic [`REG_DATA_WIDTH-1:0] rd_word;
    logic                       addr_undefined;

    assign addr_undefined = (addr >= TOTAL_REGS);

    //////////////////////////////
    // Control registers
    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            ing_enable_con  <= '1;
            egr_enable_con  <= '1;
            ing_sample_req  <= '0;
            egr_sample_req  <= '0;
            ing_port_enable <= '1;
            egr_port_enable <= '1;
        end else begin
            ing_port_enable <= ing_enable_con; // Outputs trail the register by a cycle
            egr_port_enable <= egr_enable_con;
            if (wr_en) begin
                // Only the valid port bits are kept
                case (addr)
                    ING_ENABLE_CON: ing_enable_con <= wr_data[`ING_PORTS-1:0];
                    EGR_ENABLE_CON: egr_enable_con <= wr_data[`EGR_PORTS-1:0];
                    ING_SAMPLE_CON: ing_sample_req <= wr_data[`ING_PORTS-1:0];
                    EGR_SAMPLE_CON: egr_sample_req <= wr_data[`EGR_PORTS-1:0];
                    default: ;                 // Read-only or undefined
                endcase
            end
        end
    end

    //////////////////////////////
    // Read data select
    always_comb begin : read_mux
        int unsigned ofs;
        logic [CNTRS_PER_PORT*`ING_CNT_WIDTH-1:0] ing_vec;
        logic [CNTRS_PER_PORT*`EGR_CNT_WIDTH-1:0] egr_vec;

        rd_word = '0;
        ofs     = 0;
        ing_vec = '0;
        egr_vec = '0;
        if (addr >= ING_COUNTERS_START && addr < EGR_COUNTERS_START) begin
            // Four words per port, packets first
            ofs     = int'(addr - ING_COUNTERS_START);
            ing_vec = ing_held[ofs / CNTRS_PER_PORT];
            rd_word = ing_vec[(ofs % CNTRS_PER_PORT)*`ING_CNT_WIDTH +: `ING_CNT_WIDTH];
        end else if (addr >= EGR_COUNTERS_START && !addr_undefined) begin
            ofs     = int'(addr - EGR_COUNTERS_START);
            egr_vec = egr_held[ofs / CNTRS_PER_PORT];
            rd_word = `REG_DATA_WIDTH'(
                egr_vec[(ofs % CNTRS_PER_PORT)*`EGR_CNT_WIDTH +: `EGR_CNT_WIDTH]);
        end else begin
            case (addr)
                VERSION_ID:         rd_word = {`VERSION_MAJOR, `VERSION_MINOR, `MODULE_ID};
                NUM_REGS:           rd_word = `REG_DATA_WIDTH'(TOTAL_REGS);
                ING_ENABLE_CON:     rd_word = `REG_DATA_WIDTH'(ing_enable_con);
                EGR_ENABLE_CON:     rd_word = `REG_DATA_WIDTH'(egr_enable_con);
                ING_CONNECTED_STAT: rd_word = `REG_DATA_WIDTH'(ing_connected);
                EGR_CONNECTED_STAT: rd_word = `REG_DATA_WIDTH'(egr_connected);
                ING_SAMPLE_CON:     rd_word = `REG_DATA_WIDTH'(ing_sample_req);
                EGR_SAMPLE_CON:     rd_word = `REG_DATA_WIDTH'(egr_sample_req);
                default:            rd_word = '0; // Undefined reads as zero
            endcase
        end
    end

    // Read response
    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            rd_valid <= 1'b0;
            rd_error <= 1'b0;
        end else begin
            rd_valid <= rd_en;
            rd_error <= rd_en & addr_undefined;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (rd_en) begin
            rd_data <= rd_word;
        end
    end

    // Software side issues one strobe at a time
    a_no_rd_wr_overlap: assert property (@(posedge core_clk_ifc)
        disable iff (!peripheral_sresetn_core)
        !(wr_en && rd_en));

endmodule

`default_nettype wire

//--- design/port_stats_top.sv
// Port statistics block: counter banks, snapshots and register file
// Single clock; pkt_len is packed per port, PKT_LEN_WIDTH bits each
`timescale 1ns/10ps
`include "port_stats_macros.svh"
`default_nettype none

module port_stats_top (
    input  var logic                                      core_clk_ifc,
    input  var logic                                      peripheral_sresetn_core,

    input  var logic                                      wr_en,
    input  var logic                                      rd_en,
    input  var logic [`REG_ADDR_WIDTH-1:0]                addr,
    input  var logic [`REG_DATA_WIDTH-1:0]                wr_data,
    output var logic [`REG_DATA_WIDTH-1:0]                rd_data,
    output var logic                                      rd_valid,
    output var logic                                      rd_error,

    input  var logic [`ING_PORTS-1:0]                     ing_pkt_done,
    input  var logic [`ING_PORTS-1:0][`PKT_LEN_WIDTH-1:0] ing_pkt_len,
    input  var logic [`ING_PORTS-1:0]                     ing_pkt_err,
    input  var logic [`ING_PORTS-1:0]                     ing_buf_full_drop,
    input  var logic [`EGR_PORTS-1:0]                     egr_pkt_done,
    input  var logic [`EGR_PORTS-1:0][`PKT_LEN_WIDTH-1:0] egr_pkt_len,
    input  var logic [`EGR_PORTS-1:0]                     egr_pkt_err,
    input  var logic [`EGR_PORTS-1:0]                     egr_buf_full_drop,
    input  var logic [`ING_PORTS-1:0]                     ing_connected,
    input  var logic [`EGR_PORTS-1:0]                     egr_connected,

    output var logic [`ING_PORTS-1:0]                     ing_port_enable,
    output var logic [`EGR_PORTS-1:0]                     egr_port_enable,
    output var logic [`ING_PORTS-1:0]                     ing_cnts_clear,
    output var logic [`EGR_PORTS-1:0]                     egr_cnts_clear
);

    import port_stats_pkg::*;

    ing_port_stats_t [`ING_PORTS-1:0] ing_live;
    ing_port_stats_t [`ING_PORTS-1:0] ing_held;
    egr_port_stats_t [`EGR_PORTS-1:0] egr_live;
    egr_port_stats_t [`EGR_PORTS-1:0] egr_held;
    logic            [`ING_PORTS-1:0] ing_sample_req;
    logic            [`EGR_PORTS-1:0] egr_sample_req;

    //////////////////////////////
    // Ingress path
    port_traffic_counters #(
        .NUM_PORTS ( `ING_PORTS     ),
        .CNT_WIDTH ( `ING_CNT_WIDTH )
    ) ing_counters_inst (
        .core_clk_ifc            ( core_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .pkt_done                ( ing_pkt_done            ),
        .pkt_len                 ( ing_pkt_len             ),
        .pkt_err                 ( ing_pkt_err             ),
        .buf_full_drop           ( ing_buf_full_drop       ),
        .cnts_clear              ( ing_cnts_clear          ),
        .live_stats              ( ing_live                )
    );

    port_stats_snapshot #(
        .stats_t   ( ing_port_stats_t ),
        .NUM_PORTS ( `ING_PORTS       )
    ) ing_snapshot_inst (
        .core_clk_ifc            ( core_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .sample_req              ( ing_sample_req          ),
        .live_stats              ( ing_live                ),
        .held_stats              ( ing_held                ),
        .cnts_clear              ( ing_cnts_clear          )
    );

    //////////////////////////////
    // Egress path, 24-bit counters
    port_traffic_counters #(
        .NUM_PORTS ( `EGR_PORTS     ),
        .CNT_WIDTH ( `EGR_CNT_WIDTH )
    ) egr_counters_inst (
        .core_clk_ifc            ( core_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .pkt_done                ( egr_pkt_done            ),
        .pkt_len                 ( egr_pkt_len             ),
        .pkt_err                 ( egr_pkt_err             ),
        .buf_full_drop           ( egr_buf_full_drop       ),
        .cnts_clear              ( egr_cnts_clear          ),
        .live_stats              ( egr_live                )
    );

    port_stats_snapshot #(
        .stats_t   ( egr_port_stats_t ),
        .NUM_PORTS ( `EGR_PORTS       )
    ) egr_snapshot_inst (
        .core_clk_ifc            ( core_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .sample_req              ( egr_sample_req          ),
        .live_stats              ( egr_live                ),
        .held_stats              ( egr_held                ),
        .cnts_clear              ( egr_cnts_clear          )
    );

    // Register file
    port_stats_regs port_stats_regs_inst (
        .core_clk_ifc            ( core_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .wr_en                   ( wr_en                   ),
        .rd_en                   ( rd_en                   ),
        .addr                    ( addr                    ),
        .wr_data                 ( wr_data                 ),
        .rd_data                 ( rd_data                 ),
        .rd_valid                ( rd_valid                ),
        .rd_error                ( rd_error                ),
        .ing_connected           ( ing_connected           ),
        .egr_connected           ( egr_connected           ),
        .ing_held                ( ing_held                ),
        .egr_held                ( egr_held                ),
        .ing_port_enable         ( ing_port_enable         ),
        .egr_port_enable         ( egr_port_enable         ),
        .ing_sample_req          ( ing_sample_req          ),
        .egr_sample_req          ( egr_sample_req          )
    );

endmodule

`default_nettype wire

//--- tests/port_stats_tb.sv
// Pattern-driven testbench, run from the project root so the pattern path resolves
// Expected values come from the pattern file; one operation per line
`timescale 1ns/10ps

module port_stats_tb;

    import port_stats_pkg::*;

    localparam int ING_PORTS  = 4;
    localparam int EGR_PORTS  = 2;
    localparam int LEN_WIDTH  = 16;
    localparam int RD_TIMEOUT = 20;     // Cycles allowed for rd_valid

    logic                                 core_clk_ifc;
    logic                                 peripheral_sresetn_core;
    logic                                 wr_en;
    logic                                 rd_en;
    logic [5:0]                           addr;
    logic [31:0]                          wr_data;
    logic [31:0]                          rd_data;
    logic                                 rd_valid;
    logic                                 rd_error;
    logic [ING_PORTS-1:0]                 ing_pkt_done;
    logic [ING_PORTS-1:0][LEN_WIDTH-1:0]  ing_pkt_len;
    logic [ING_PORTS-1:0]                 ing_pkt_err;
    logic [ING_PORTS-1:0]                 ing_buf_full_drop;
    logic [EGR_PORTS-1:0]                 egr_pkt_done;
    logic [EGR_PORTS-1:0][LEN_WIDTH-1:0]  egr_pkt_len;
    logic [EGR_PORTS-1:0]                 egr_pkt_err;
    logic [EGR_PORTS-1:0]                 egr_buf_full_drop;
    logic [ING_PORTS-1:0]                 ing_connected;
    logic [EGR_PORTS-1:0]                 egr_connected;
    logic [ING_PORTS-1:0]                 ing_port_enable;
    logic [EGR_PORTS-1:0]                 egr_port_enable;
    logic [ING_PORTS-1:0]                 ing_cnts_clear;
    logic [EGR_PORTS-1:0]                 egr_cnts_clear;

    int errors    = 0;
    int checks    = 0;
    bit timed_out = 0;
    int seed      = 32'ha80d;
    int ing_clear_cnt [ING_PORTS] = '{default: 0};
    int egr_clear_cnt [EGR_PORTS] = '{default: 0};

    always #10 core_clk_ifc = ~core_clk_ifc;    // 20 ns period

    port_stats_top port_stats_top_inst (.*);

    // Clear pulses are one cycle wide, so each is counted once
    always @(negedge core_clk_ifc) begin
        for (int p = 0; p < ING_PORTS; p++) begin
            if (ing_cnts_clear[p]) ing_clear_cnt[p]++;
        end
        for (int p = 0; p < EGR_PORTS; p++) begin
            if (egr_cnts_clear[p]) egr_clear_cnt[p]++;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    //////////////////////////////
    // Bus and traffic drivers
    task automatic drive_traffic(input logic [31:0] dir, input logic [31:0] port,
                                 input logic [31:0] count, input logic [31:0] len,
                                 input logic [31:0] err, input logic [31:0] drop);
        for (int i = 0; i < int'(count); i++) begin
            @(posedge core_clk_ifc);
            #2;
            if (dir == 0) begin
                ing_pkt_done[port[1:0]]      = 1'b1;
                ing_pkt_len[port[1:0]]       = len[LEN_WIDTH-1:0];
                ing_pkt_err[port[1:0]]       = err[0];
                ing_buf_full_drop[port[1:0]] = drop[0];
            end else begin
                egr_pkt_done[port[0]]      = 1'b1;
                egr_pkt_len[port[0]]       = len[LEN_WIDTH-1:0];
                egr_pkt_err[port[0]]       = err[0];
                egr_buf_full_drop[port[0]] = drop[0];
            end
        end
        @(posedge core_clk_ifc);
        #2;
        ing_pkt_done = '0;
        ing_pkt_len  = '0;
        ing_pkt_err  = '0;
        ing_buf_full_drop = '0;
        egr_pkt_done = '0;
        egr_pkt_len  = '0;
        egr_pkt_err  = '0;
        egr_buf_full_drop = '0;
    endtask

    task automatic write_reg(input logic [5:0] a, input logic [31:0] d);
        @(posedge core_clk_ifc);
        #2;
        wr_en   = 1'b1;
        addr    = a;
        wr_data = d;
        @(posedge core_clk_ifc);
        #2;
        wr_en   = 1'b0;
    endtask

    task automatic read_reg(input logic [5:0] a, output logic [31:0] data, output logic err);
        int waited;
        waited = 0;
        @(posedge core_clk_ifc);
        #2;
        rd_en = 1'b1;
        addr  = a;
        @(posedge core_clk_ifc);
        #2;
        rd_en = 1'b0;
        @(negedge core_clk_ifc);
        while (!rd_valid && waited < RD_TIMEOUT) begin
            @(negedge core_clk_ifc);
            waited++;
        end
        if (!rd_valid) begin
            timed_out = 1'b1;
            errors++;
            $display("Timeout waiting for rd_valid on a read of address %h", a);
        end
        data = rd_data;
        err  = rd_error;
    endtask

    //////////////////////////////
    // Main sequence
    initial begin
        int          fd;
        int          n;
        int          gap;
        string       line;
        logic [31:0] op, f1, f2, f3, f4, f5, f6;
        logic [31:0] data;
        logic        err;

        core_clk_ifc = 1'b0;
        peripheral_sresetn_core = 1'b0;
        wr_en = 1'b0;
        rd_en = 1'b0;
        addr = '0;
        wr_data = '0;
        ing_pkt_done = '0;
        ing_pkt_len = '0;
        ing_pkt_err = '0;
        ing_buf_full_drop = '0;
        egr_pkt_done = '0;
        egr_pkt_len = '0;
        egr_pkt_err = '0;
        egr_buf_full_drop = '0;
        ing_connected = '0;
        egr_connected = '0;

        repeat (4) @(posedge core_clk_ifc);
        #2;
        peripheral_sresetn_core = 1'b1;

        fd = $fopen("tests/port_stats_patterns.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the pattern file");
        end else begin
            while (!timed_out && !$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h", op, f1, f2, f3, f4, f5, f6);
                    case (op)
                        1: drive_traffic(f1, f2, f3, f4, f5, f6);
                        2: write_reg(f1[5:0], f2);
                        3: begin
                            read_reg(f1[5:0], data, err);
                            if (!timed_out) begin
                                check_value($sformatf("rd_error @%h", f1), {31'b0, err}, 0);
                                check_value($sformatf("rd_data @%h", f1), data, f2);
                            end
                        end
                        4: begin
                            if (f1 < 32'(TOTAL_REGS)) begin
                                errors++;
                                $display("Error read pattern names a defined address %h", f1);
                            end
                            read_reg(f1[5:0], data, err);
                            if (!timed_out) begin
                                check_value($sformatf("rd_error @%h", f1), {31'b0, err}, 1);
                                check_value($sformatf("rd_data @%h", f1), data, 0);
                            end
                        end
                        5: begin
                            @(posedge core_clk_ifc);
                            #2;
                            ing_connected = f1[ING_PORTS-1:0];
                            egr_connected = f2[EGR_PORTS-1:0];
                        end
                        6: begin
                            @(negedge core_clk_ifc);
                            check_value("ing_port_enable", 32'(ing_port_enable), f1);
                            check_value("egr_port_enable", 32'(egr_port_enable), f2);
                        end
                        7: begin
                            if (f1 == 0) begin
                                check_value("ing_cnts_clear pulses",
                                            32'(ing_clear_cnt[f2[1:0]]), f3);
                            end else begin
                                check_value("egr_cnts_clear pulses",
                                            32'(egr_clear_cnt[f2[0]]), f3);
                            end
                        end
                        default: begin
                            errors++;
                            $display("Unknown operation %h in the pattern file", op);
                        end
                    endcase
                    gap = 2 + ($unsigned($random(seed)) % 4);  // Idle cycles between ops
                    repeat (gap) @(posedge core_clk_ifc);
                end
            end
            $fclose(fd);
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- tests/port_stats_patterns.txt
# Fields in hex. 1 traffic: dir(0 ing, 1 egr) port count len err drop | 2 write: addr data
# 3 read: addr expected | 4 read error: addr | 5 connected: ing egr | 6 enables: ing egr | 7 clears: dir port pulses
6 f 3
3 0 01005053
3 1 20
3 4 0
3 6 0
3 7 0
3 2 f
3 3 3
# Enable control, masked to the port bits
2 2 fffffff5
3 2 5
6 5 3
2 3 fe
3 3 2
6 5 2
2 2 f
2 3 3
3 2 f
6 f 3
# Ingress port 1 burst, then sample
1 0 1 10 40 1 0
1 0 1 3 20 0 1
2 6 2
3 6 2
3 c 13
3 d 460
3 e 10
3 f 3
3 8 0
7 0 1 1
# Lower the bit, new traffic, raise again
2 6 0
1 0 1 5 100 0 0
2 6 2
3 c 5
3 d 500
3 e 0
3 f 0
7 0 1 2
# Egress port 0, byte count wraps at 24 bits
1 1 0 200 ffff 1 1
2 7 1
3 18 200
3 19 fffe00
3 1a 200
3 1b 200
3 1c 0
7 1 0 1
# Status words and undefined addresses
5 a 1
3 4 a
3 5 1
2 4 0
3 4 a
2 18 0
3 18 200
4 20
4 3f

//--- files.f
+incdir+include
design/port_stats_pkg.sv
design/port_traffic_counters.sv
design/port_stats_snapshot.sv
design/port_stats_regs.sv
design/port_stats_top.sv
tests/port_stats_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the port statistics testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f files.f \
    --top-module port_stats_tb \
    --Mdir obj_dir

out=$(./obj_dir/Vport_stats_tb)
echo "$out"

if echo "$out" | grep -qx "Simulation passed"; then
    exit 0
else
    exit 1
fi
